// File: Makefile
# Verilator flow for the MMIO AFU
# make lint, make sim, make clean

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= mmio_afu_tb
RTL_TOP   ?= mmio_afu_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/mmio_afu_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the RTL on its own, then the whole testbench build
lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include \
		$(filter verilog/%,$(SOURCES)) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Output goes to the terminal; the status comes from the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/mmio_afu_cfg.svh
// MMIO AFU build configuration
// Sizes of the request buffer and register file, and the widths of the
// host-visible address and read tag. One build uses one configuration

`ifndef MMIO_AFU_CFG_SVH
`define MMIO_AFU_CFG_SVH

// ====================
// Request path sizing
// ====================

// Entries in the request buffer, which is also the credit count at reset
`define MMIO_AFU_BUF_DEPTH 4

// ====================
// Register file
// ====================

// Number of 64-bit registers behind the MMIO ports
`define MMIO_AFU_NUM_REGS 16

// Word address width, counted in 64-bit units
`define MMIO_AFU_ADDR_W 8

// Read tag width, chosen by the host and echoed in the response
`define MMIO_AFU_TAG_W 4

// Value that register 0 always returns
`define MMIO_AFU_ID 64'h4d4d_494f_0af0_0001

`endif

// File: project.f
+incdir+include
verilog/mmio_afu_pkg.sv
verilog/mmio_host_adapter.sv
verilog/mmio_req_buffer.sv
verilog/mmio_afu_regs.sv
verilog/mmio_afu_top.sv
verification/mmio_afu_tb.sv

// File: verification/mmio_afu_tb.sv
// MMIO AFU testbench
// Drives both host MMIO ports with LCG stimulus and keeps a register
// model updated at each host transfer. Concurrent assertions compare
// every read response, in issue order, with the model's prediction

`timescale 1ns/1ps

`include "mmio_afu_cfg.svh"

module mmio_afu_tb;

    import mmio_afu_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int DEPTH      = `MMIO_AFU_BUF_DEPTH;
    localparam int NUM_REGS   = `MMIO_AFU_NUM_REGS;

    logic       clk;
    logic       rst;
    logic       mmio64_valid;
    mmio_kind_e mmio64_kind;
    mmio_addr_t mmio64_addr;
    mmio_tag_t  mmio64_tag;
    mmio_word_t mmio64_data;
    logic       mmio64_ready;
    logic       mmio512_valid;
    mmio_addr_t mmio512_addr;
    mmio_line_t mmio512_data;
    logic       mmio512_ready;
    logic       rsp_valid;
    mmio_rsp_t  rsp;
    logic       rsp_ready;

    // Reference state, expected responses and stall bookkeeping
    mmio_word_t  model [NUM_REGS];
    mmio_rsp_t   exp_q [$];
    mmio_rsp_t   exp_head;
    int          exp_count;
    int          stall_accepts;
    logic        hold_rsp;
    logic [31:0] stim_seed;
    logic [31:0] rdy_seed;
    int          check_errors;
    int          timeout_errors;

    mmio_afu_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .mmio64_valid  (mmio64_valid),
        .mmio64_kind   (mmio64_kind),
        .mmio64_addr   (mmio64_addr),
        .mmio64_tag    (mmio64_tag),
        .mmio64_data   (mmio64_data),
        .mmio64_ready  (mmio64_ready),
        .mmio512_valid (mmio512_valid),
        .mmio512_addr  (mmio512_addr),
        .mmio512_data  (mmio512_data),
        .mmio512_ready (mmio512_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready)
    );

    always #20 clk = ~clk;

    // ====================
    // Random numbers
    // ====================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed;
    endfunction

    function automatic mmio_word_t rand_word();
        return {next_rand(), next_rand()};
    endfunction

    function automatic mmio_line_t rand_line();
        mmio_line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i] = rand_word();
        end
        return l;
    endfunction

    // Host accepts about three responses in four, unless a stall is forced
    always @(posedge clk) begin
        rdy_seed <= lcg_step(rdy_seed);
        if (hold_rsp) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= (rdy_seed[17:16] != 2'b00);
        end
    end

    // ====================
    // Register model
    // ====================

    // Register 0 is the identifier and words past the file read as all ones
    function automatic mmio_word_t ref_read(input mmio_addr_t a);
        if (a == 0) begin
            return `MMIO_AFU_ID;
        end
        if (int'(a) < NUM_REGS) begin
            return model[int'(a)];
        end
        return {64{1'b1}};
    endfunction

    function automatic void ref_write(input mmio_addr_t a, input mmio_word_t d);
        if (a != 0 && int'(a) < NUM_REGS) begin
            model[int'(a)] = d;
        end
    endfunction

    // The model follows host transfers, and the single in-order path keeps
    // the register block in step with it
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            for (int r = 0; r < NUM_REGS; r++) begin
                model[r] = '0;
            end
            exp_count     <= 0;
            exp_head      <= '0;
            stall_accepts <= 0;
        end else begin
            if (rsp_valid && rsp_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (mmio64_valid && mmio64_ready) begin
                if (mmio64_kind == RD64) begin
                    exp_q.push_back({mmio64_tag, ref_read(mmio64_addr)});
                end else begin
                    ref_write(mmio64_addr, mmio64_data);
                end
            end
            if (mmio512_valid && mmio512_ready) begin
                // Line base is the address rounded down to eight words
                for (int i = 0; i < 8; i++) begin
                    ref_write((mmio512_addr & ~mmio_addr_t'(7)) + mmio_addr_t'(i),
                              mmio512_data[i]);
                end
            end
            exp_count <= exp_q.size();
            exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
            if (!hold_rsp) begin
                stall_accepts <= 0;
            end else if ((mmio64_valid && mmio64_ready) || (mmio512_valid && mmio512_ready)) begin
                stall_accepts <= stall_accepts + 1;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    // Every cycle that follows a reset edge starts quiet
    reset_quiet_a : assert property (
        @(posedge clk) rst |=> (!rsp_valid && !mmio64_ready && !mmio512_ready)
    ) else begin
        check_errors++;
        $display("Fail %0t: host ready or response active after reset", $time);
    end

    idle_ready_a : assert property (
        @(posedge clk) (!mmio64_ready || mmio64_valid) && (!mmio512_ready || mmio512_valid)
    ) else begin
        check_errors++;
        $display("Fail %0t: host ready raised without a valid request", $time);
    end

    rsp_expected_a : assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready) |-> (exp_count != 0)
    ) else begin
        check_errors++;
        $display("Fail %0t: response %h with no read outstanding", $time, $sampled(rsp));
    end

    rsp_match_a : assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready && exp_count != 0) |-> (rsp == exp_head)
    ) else begin
        check_errors++;
        $display("Fail %0t: response got %h expected %h", $time, $sampled(rsp),
                 $sampled(exp_head));
    end

    rsp_hold_a : assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else begin
        check_errors++;
        $display("Fail %0t: stalled response dropped or changed", $time);
    end

    // Once the buffer and the stalled register block are full, the host waits
    stall_bound_a : assert property (
        @(posedge clk) disable iff (rst)
        (hold_rsp && stall_accepts > DEPTH) |-> (!mmio64_ready && !mmio512_ready)
    ) else begin
        check_errors++;
        $display("Fail %0t: host ready after %0d stalled accepts", $time,
                 $sampled(stall_accepts));
    end

    // ====================
    // Host transactions
    // ====================

    task automatic send64(input mmio_kind_e kind, input mmio_addr_t addr,
                          input mmio_tag_t tag, input mmio_word_t data);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        @(posedge clk);
        mmio64_valid <= 1'b1;
        mmio64_kind  <= kind;
        mmio64_addr  <= addr;
        mmio64_tag   <= tag;
        mmio64_data  <= data;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (mmio64_ready) begin
                taken = 1'b1;
            end else begin
                waited++;
            end
        end
        // Transfer edge or the give-up point
        @(posedge clk);
        mmio64_valid <= 1'b0;
        if (!taken) begin
            timeout_errors++;
            $display("Timeout: 64-bit request to word %0d was never accepted", addr);
        end
    endtask

    task automatic send512(input mmio_addr_t addr, input mmio_line_t line);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        @(posedge clk);
        mmio512_valid <= 1'b1;
        mmio512_addr  <= addr;
        mmio512_data  <= line;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (mmio512_ready) begin
                taken = 1'b1;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        mmio512_valid <= 1'b0;
        if (!taken) begin
            timeout_errors++;
            $display("Timeout: 512-bit write to word %0d was never accepted", addr);
        end
    endtask

    // Waits until every issued read has been answered, then lets the
    // last writes reach the register file
    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((exp_count != 0 || rsp_valid) && waited < WAIT_LIMIT);
        if (exp_count != 0 || rsp_valid) begin
            timeout_errors++;
            $display("Timeout: %0d read responses never arrived", exp_count);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic read_all();
        logic [31:0] r;
        for (int a = 0; a < NUM_REGS; a++) begin
            r = next_rand();
            send64(RD64, mmio_addr_t'(a), mmio_tag_t'(r[27:24]), '0);
        end
    endtask

    // Reads keep coming with no response taken, so the credits run out
    task automatic stall_responses();
        int          waited;
        logic        taken;
        logic [31:0] r;
        drain();
        r = next_rand();
        @(posedge clk);
        hold_rsp     <= 1'b1;
        mmio64_valid <= 1'b1;
        mmio64_kind  <= RD64;
        mmio64_addr  <= mmio_addr_t'(r[19:16]);
        mmio64_tag   <= mmio_tag_t'(r[23:20]);
        for (int c = 0; c < 4 * DEPTH + 8; c++) begin
            @(negedge clk);
            taken = mmio64_ready;
            r = next_rand();
            @(posedge clk);
            if (taken) begin
                mmio64_addr <= mmio_addr_t'(r[19:16]);
                mmio64_tag  <= mmio_tag_t'(r[23:20]);
            end
        end
        hold_rsp <= 1'b0;
        // The read still on offer goes in once responses move again
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (mmio64_ready) begin
                taken = 1'b1;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        mmio64_valid <= 1'b0;
        if (!taken) begin
            timeout_errors++;
            $display("Timeout: host port stayed blocked after the stall ended");
        end
        drain();
    endtask

    // Arguments are drawn first so both ports run from a fixed sequence
    task automatic both_ports();
        mmio_line_t  lines [6];
        mmio_addr_t  laddr [6];
        mmio_kind_e  kinds [12];
        mmio_addr_t  waddr [12];
        mmio_tag_t   tags  [12];
        mmio_word_t  words [12];
        logic [31:0] r;
        for (int j = 0; j < 6; j++) begin
            r = next_rand();
            laddr[j] = mmio_addr_t'(r[19:16]);
            lines[j] = rand_line();
        end
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            kinds[i] = r[21] ? WR64 : RD64;
            waddr[i] = mmio_addr_t'(r[19:16]);
            tags[i]  = mmio_tag_t'(r[27:24]);
            words[i] = rand_word();
        end
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    send64(kinds[i], waddr[i], tags[i], words[i]);
                end
            end
            begin
                for (int j = 0; j < 6; j++) begin
                    send512(laddr[j], lines[j]);
                end
            end
        join
        read_all();
        drain();
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        logic [31:0] r;
        clk            = 1'b0;
        rst            = 1'b1;
        mmio64_valid   = 1'b0;
        mmio64_kind    = RD64;
        mmio64_addr    = '0;
        mmio64_tag     = '0;
        mmio64_data    = '0;
        mmio512_valid  = 1'b0;
        mmio512_addr   = '0;
        mmio512_data   = '0;
        rsp_ready      = 1'b0;
        hold_rsp       = 1'b0;
        stim_seed      = 32'h17d4;
        rdy_seed       = lcg_step(32'h17d4);
        check_errors   = 0;
        timeout_errors = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Identifier in register 0, zeros everywhere else
        read_all();
        drain();

        // Mixed single-word traffic, register 0 included
        for (int n = 0; n < 32; n++) begin
            r = next_rand();
            send64(r[20] ? WR64 : RD64, mmio_addr_t'(r[11:8]), mmio_tag_t'(r[15:12]),
                   rand_word());
        end
        send64(WR64, '0, '0, rand_word());
        read_all();
        drain();

        // Line writes from unaligned addresses, read back lane by lane
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            send512(mmio_addr_t'(r[11:8]), rand_line());
            read_all();
        end
        drain();

        // Words past the register file
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            send64(RD64, mmio_addr_t'(NUM_REGS + int'(r[15:8]) % (256 - NUM_REGS)),
                   mmio_tag_t'(r[19:16]), '0);
            r = next_rand();
            send64(WR64, mmio_addr_t'(NUM_REGS + int'(r[15:8]) % (256 - NUM_REGS)),
                   '0, rand_word());
        end
        send512(mmio_addr_t'(NUM_REGS + 3), rand_line());
        send512(mmio_addr_t'(255), rand_line());
        read_all();
        drain();

        stall_responses();
        both_ports();

        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verilog/mmio_afu_pkg.sv
// MMIO AFU shared types
// Vector types for addresses, tags and data, the request kind and the
// register block state, and the request and response records that move
// between the host adapter, the request buffer and the register block

`include "mmio_afu_cfg.svh"

package mmio_afu_pkg;

    // ====================
    // Vector types
    // ====================

    // Word address in 64-bit units
    typedef logic [`MMIO_AFU_ADDR_W-1:0] mmio_addr_t;

    // Read tag, carried through unchanged
    typedef logic [`MMIO_AFU_TAG_W-1:0] mmio_tag_t;

    // One 64-bit data word
    typedef logic [63:0] mmio_word_t;

    // One 512-bit line, lane 0 is the lowest word
    typedef logic [7:0][63:0] mmio_line_t;

    // Credit counter, holds every value from zero up to the buffer depth
    typedef logic [$clog2(`MMIO_AFU_BUF_DEPTH + 1)-1:0] credit_cnt_t;

    // ====================
    // Enumerations
    // ====================

    // What a request asks the register block to do
    typedef enum logic [1:0] {
        RD64  = 2'd0,
        WR64  = 2'd1,
        WR512 = 2'd2
    } mmio_kind_e;

    // Register block FSM, RSP_WAIT holds a read response for the host
    typedef enum logic {
        IDLE     = 1'b0,
        RSP_WAIT = 1'b1
    } regs_state_e;

    // ====================
    // Records
    // ====================

    // A request as it travels from the adapter to the register block
    // A 64-bit write puts its data in lane 0 of the line
    typedef struct packed {
        mmio_kind_e kind;
        mmio_addr_t addr;
        mmio_tag_t  tag;
        mmio_line_t line;
    } mmio_req_t;

    // A read response back to the host
    typedef struct packed {
        mmio_tag_t  tag;
        mmio_word_t data;
    } mmio_rsp_t;

endpackage

// File: verilog/mmio_afu_regs.sv
// MMIO AFU register block
// Register file behind the request buffer. Applies 64-bit and 512-bit
// writes, answers 64-bit reads and holds each read response until the
// host takes it. Register 0 is a read-only identifier

`timescale 1ns/1ps

`include "mmio_afu_cfg.svh"

module mmio_afu_regs (
    input  logic                    clk,
    input  logic                    rst,
    // Requests from the buffer
    input  logic                    buf_valid,
    input  mmio_afu_pkg::mmio_req_t buf_req,
    output logic                    buf_ready,
    // Read responses to the host
    output logic                    rsp_valid,
    output mmio_afu_pkg::mmio_rsp_t rsp,
    input  logic                    rsp_ready
);

    import mmio_afu_pkg::*;

    localparam int NUM_REGS = `MMIO_AFU_NUM_REGS;
    localparam int IDX_W    = $clog2(NUM_REGS);
    localparam int LANES    = $bits(mmio_line_t) / $bits(mmio_word_t);

    // Register 0 has no storage, it always reads as the identifier
    mmio_word_t  regs [1:NUM_REGS-1];
    regs_state_e state;
    logic        accept;
    logic        is_read;
    mmio_word_t  rd_word;
    mmio_addr_t  lane_addr [LANES];
    logic        lane_we   [LANES];

    // True for a word that has storage behind it
    function automatic logic writable(mmio_addr_t a);
        return (a != '0) && (a < mmio_addr_t'(NUM_REGS));
    endfunction

    // ====================
    // Request acceptance
    // ====================

    // A pending read response blocks the next request
    assign buf_ready = (state == IDLE);
    assign accept    = buf_valid && buf_ready;
    assign is_read   = (buf_req.kind == RD64);
    assign rsp_valid = (state == RSP_WAIT);

    // ====================
    // Write path
    // ====================

    // Every write is handled as lanes, a 64-bit write only enables lane 0.
    // Line addresses are aligned, so the lane offset never carries out
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_addr[i] = buf_req.addr + mmio_addr_t'(i);
            lane_we[i]   = accept && writable(lane_addr[i])
                           && ((buf_req.kind == WR512) || (buf_req.kind == WR64 && i == 0));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_we[i]) begin
                    regs[lane_addr[i][IDX_W-1:0]] <= buf_req.line[i];
                end
            end
        end
    end

    // ====================
    // Read path
    // ====================

    // Words past the register file read as all ones
    always_comb begin
        if (buf_req.addr == '0) begin
            rd_word = `MMIO_AFU_ID;
        end else if (writable(buf_req.addr)) begin
            rd_word = regs[buf_req.addr[IDX_W-1:0]];
        end else begin
            rd_word = '1;
        end
    end

    // Response payload is captured once and then held while stalled
    always_ff @(posedge clk) begin
        if (accept && is_read) begin
            rsp.tag  <= buf_req.tag;
            rsp.data <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && is_read) begin
                        state <= RSP_WAIT;
                    end
                end
                RSP_WAIT: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A stalled response keeps its tag and data until the host takes it
    rsp_stable_a : assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("read response changed while stalled");

endmodule

// File: verilog/mmio_afu_top.sv
// MMIO AFU top level
// Host MMIO ports feed the host adapter, which sends requests through
// the credit-controlled request buffer to the register block. Read
// responses return to the host with a ready/valid handshake

`timescale 1ns/1ps

module mmio_afu_top (
    input  logic                     clk,
    input  logic                     rst,
    // 64-bit read/write MMIO port
    input  logic                     mmio64_valid,
    input  mmio_afu_pkg::mmio_kind_e mmio64_kind,
    input  mmio_afu_pkg::mmio_addr_t mmio64_addr,
    input  mmio_afu_pkg::mmio_tag_t  mmio64_tag,
    input  mmio_afu_pkg::mmio_word_t mmio64_data,
    output logic                     mmio64_ready,
    // 512-bit write-only MMIO port
    input  logic                     mmio512_valid,
    input  mmio_afu_pkg::mmio_addr_t mmio512_addr,
    input  mmio_afu_pkg::mmio_line_t mmio512_data,
    output logic                     mmio512_ready,
    // Read responses
    output logic                     rsp_valid,
    output mmio_afu_pkg::mmio_rsp_t  rsp,
    input  logic                     rsp_ready
);

    import mmio_afu_pkg::*;

    // Adapter to buffer, credit based
    logic      req_valid;
    mmio_req_t req;
    logic      credit_return;

    // Buffer to register block, ready/valid
    logic      buf_valid;
    mmio_req_t buf_req;
    logic      buf_ready;

    // ====================
    // Producer
    // ====================

    mmio_host_adapter adapter_i (
        .clk           (clk),
        .rst           (rst),
        .mmio64_valid  (mmio64_valid),
        .mmio64_kind   (mmio64_kind),
        .mmio64_addr   (mmio64_addr),
        .mmio64_tag    (mmio64_tag),
        .mmio64_data   (mmio64_data),
        .mmio64_ready  (mmio64_ready),
        .mmio512_valid (mmio512_valid),
        .mmio512_addr  (mmio512_addr),
        .mmio512_data  (mmio512_data),
        .mmio512_ready (mmio512_ready),
        .credit_return (credit_return),
        .req_valid     (req_valid),
        .req           (req)
    );

    // Buffer depth sets how far the host can run ahead of the registers
    mmio_req_buffer buffer_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .buf_valid     (buf_valid),
        .buf_req       (buf_req),
        .buf_ready     (buf_ready)
    );

    // ====================
    // Consumer
    // ====================

    mmio_afu_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .buf_valid (buf_valid),
        .buf_req   (buf_req),
        .buf_ready (buf_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

endmodule

// File: verilog/mmio_host_adapter.sv
// MMIO host adapter
// Merges the 64-bit read/write port and the 512-bit write port into one
// request stream. Each request costs one credit from the request buffer,
// and both host ports stall while no credit is left

`timescale 1ns/1ps

`include "mmio_afu_cfg.svh"

module mmio_host_adapter (
    input  logic                     clk,
    input  logic                     rst,
    // 64-bit read/write port
    input  logic                     mmio64_valid,
    input  mmio_afu_pkg::mmio_kind_e mmio64_kind,
    input  mmio_afu_pkg::mmio_addr_t mmio64_addr,
    input  mmio_afu_pkg::mmio_tag_t  mmio64_tag,
    input  mmio_afu_pkg::mmio_word_t mmio64_data,
    output logic                     mmio64_ready,
    // 512-bit write-only port
    input  logic                     mmio512_valid,
    input  mmio_afu_pkg::mmio_addr_t mmio512_addr,
    input  mmio_afu_pkg::mmio_line_t mmio512_data,
    output logic                     mmio512_ready,
    // Credit-based link to the request buffer
    input  logic                     credit_return,
    output logic                     req_valid,
    output mmio_afu_pkg::mmio_req_t  req
);

    import mmio_afu_pkg::*;

    credit_cnt_t credit_cnt;
    logic        have_credit;
    logic        grant64;
    logic        grant512;
    logic        send;
    // Set when the 64-bit port won last, so the 512-bit port goes next
    logic        prefer_512;
    mmio_req_t   req_next;

    // ====================
    // Arbitration
    // ====================

    assign have_credit = (credit_cnt != '0);

    // With both ports valid the grant alternates, otherwise the only
    // valid port wins whenever a credit is available
    assign grant64  = have_credit && mmio64_valid && (!mmio512_valid || !prefer_512);
    assign grant512 = have_credit && mmio512_valid && (!mmio64_valid || prefer_512);
    assign send     = grant64 || grant512;

    assign mmio64_ready  = grant64;
    assign mmio512_ready = grant512;

    always_ff @(posedge clk) begin
        if (rst) begin
            prefer_512 <= 1'b0;
        end else if (grant64) begin
            prefer_512 <= 1'b1;
        end else if (grant512) begin
            prefer_512 <= 1'b0;
        end
    end

    // ====================
    // Request packing
    // ====================

    always_comb begin
        req_next = '0;
        if (grant512) begin
            req_next.kind = WR512;
            // Line writes always start on an eight word boundary
            req_next.addr = {mmio512_addr[`MMIO_AFU_ADDR_W-1:3], 3'b000};
            req_next.line = mmio512_data;
        end else begin
            req_next.kind    = mmio64_kind;
            req_next.addr    = mmio64_addr;
            req_next.tag     = mmio64_tag;
            req_next.line[0] = mmio64_data;
        end
    end

    // The granted request goes out one cycle after the host transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            req <= req_next;
        end
    end

    // ====================
    // Credit counter
    // ====================

    // A credit is spent at the grant and a returned one is added back;
    // both can happen in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_cnt_t'(`MMIO_AFU_BUF_DEPTH);
        end else begin
            credit_cnt <= credit_cnt + credit_cnt_t'(credit_return) - credit_cnt_t'(send);
        end
    end

    // More credits than buffer entries means the buffer returned a credit
    // for an entry it never received
    credit_bound_a : assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= credit_cnt_t'(`MMIO_AFU_BUF_DEPTH)
    ) else $error("credit count above buffer depth");

endmodule

// File: verilog/mmio_req_buffer.sv
// MMIO request buffer
// Circular FIFO between the host adapter and the register block.
// Entries arrive under credit control and every entry that leaves
// hands one credit back to the adapter

`timescale 1ns/1ps

`include "mmio_afu_cfg.svh"

module mmio_req_buffer (
    input  logic                    clk,
    input  logic                    rst,
    // From the host adapter
    input  logic                    req_valid,
    input  mmio_afu_pkg::mmio_req_t req,
    output logic                    credit_return,
    // To the register block
    output logic                    buf_valid,
    output mmio_afu_pkg::mmio_req_t buf_req,
    input  logic                    buf_ready
);

    import mmio_afu_pkg::*;

    localparam int DEPTH = `MMIO_AFU_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // Storage holds payload only, the pointers say which entries are live
    mmio_req_t   mem [DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    credit_cnt_t count;
    logic        push;
    logic        pop;
    logic        full;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t p);
        ptr_t nxt;
        if (p == ptr_t'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = p + ptr_t'(1);
        end
        return nxt;
    endfunction

    // ====================
    // Status and handshakes
    // ====================

    assign full      = (count == credit_cnt_t'(DEPTH));
    assign buf_valid = (count != '0);
    assign buf_req   = mem[rd_ptr];
    assign push      = req_valid;
    assign pop       = buf_valid && buf_ready;

    // Each entry taken by the register block frees a slot at once
    assign credit_return = pop;

    // ====================
    // Storage and pointers
    // ====================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
        end
    end

    // The adapter only sends with a credit in hand, so a push into a full
    // buffer means the two sides disagree about the credit count
    no_push_when_full_a : assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> !full
    ) else $error("request arrived while the buffer was full");

endmodule
